// File: verilog/mif_ctrl_pkg.sv
// MIF controller common types
package mif_ctrl_pkg;

  // widths fixed by the register map
  localparam int UIF_DATA_W  = 32;
  localparam int CTRL_DATA_W = 16;
  localparam int CTRL_ADDR_W = 12;
  localparam int AV_ADDR_W   = 11;   // zero-extended onto ctrl_addr
  localparam int MIF_BASE_W  = 32;
  localparam int MIF_ERR_W   = 3;

  typedef logic [UIF_DATA_W-1:0]  uif_data_t;
  typedef logic [CTRL_DATA_W-1:0] ctrl_data_t;
  typedef logic [CTRL_ADDR_W-1:0] ctrl_addr_t;
  typedef logic [AV_ADDR_W-1:0]   av_addr_t;
  typedef logic [MIF_BASE_W-1:0]  mif_base_t;
  typedef logic [MIF_ERR_W-1:0]   mif_err_t;  // [0] addr, [1] opcode, [2] pll

  // user operation
  typedef enum logic [2:0] {
    UIF_MODE_RD = 3'd0,
    UIF_MODE_WR = 3'd1
  } uif_mode_e;

  // access mode
  typedef enum logic [1:0] {
    MIF_STREAM_MODE  = 2'b00,  // register file, avalon streaming
    MIF_DIRECT_MODE  = 2'b01,  // direct writes with pma protection
    UIF_LDIRECT_MODE = 2'b10,  // logical address
    UIF_PDIRECT_MODE = 2'b11   // physical address
  } mif_mode_e;

  // basic block opcodes
  typedef enum logic [2:0] {
    CTRL_OP_RD  = 3'h0,
    CTRL_OP_WR  = 3'h1,
    CTRL_OP_PRD = 3'h5,
    CTRL_OP_PWR = 3'h6
  } ctrl_op_e;

  typedef enum logic [2:0] {
    CTRL_IDLE, CTRL_WF_AV, CTRL_CHK_ADDR, CTRL_MIF_RD, CTRL_MIF_WR, CTRL_WF_B, CTRL_RMW
  } ctrl_state_e;

  // stream mode register offsets
  localparam ctrl_addr_t MIF_ADDR_OFFSET = 12'd0;
  localparam ctrl_addr_t MIF_CTRL_OFFSET = 12'd1;
  localparam ctrl_addr_t MIF_ERR_OFFSET  = 12'd2;
  localparam ctrl_addr_t MIF_LAST_OFFSET = 12'd2;

endpackage

// File: verilog/pma_rmw_pkg.sv
// PMA protected offsets
package pma_rmw_pkg;

  // offsets that need read-modify-write
  localparam mif_ctrl_pkg::ctrl_addr_t PMA_CGB_OFST   = 12'h011;
  localparam mif_ctrl_pkg::ctrl_addr_t PMA_BBPD_OFST  = 12'h01a;
  localparam mif_ctrl_pkg::ctrl_addr_t PMA_RREF_OFST  = 12'h01c;
  localparam mif_ctrl_pkg::ctrl_addr_t PMA_OC_OFST    = 12'h025;
  localparam mif_ctrl_pkg::ctrl_addr_t PMA_RXBUF_OFST = 12'h027;
  localparam mif_ctrl_pkg::ctrl_addr_t PMA_DCD_OFST   = 12'h02e;

  // preserve masks, a set bit keeps the old value
  localparam mif_ctrl_pkg::ctrl_data_t PMA_CGB_MASK   = 16'h0180;  // cgb clock select
  localparam mif_ctrl_pkg::ctrl_data_t PMA_BBPD_MASK  = 16'h0e00;
  localparam mif_ctrl_pkg::ctrl_data_t PMA_RREF_MASK  = 16'h0003;  // rref select
  localparam mif_ctrl_pkg::ctrl_data_t PMA_OC_MASK    = 16'h003f;
  localparam mif_ctrl_pkg::ctrl_data_t PMA_RXBUF_MASK = 16'hf000;
  localparam mif_ctrl_pkg::ctrl_data_t PMA_DCD_MASK   = 16'h0c00;  // dcd control

  function automatic logic is_rmw_offset(input mif_ctrl_pkg::ctrl_addr_t addr);
    case (addr)
      PMA_CGB_OFST, PMA_BBPD_OFST, PMA_RREF_OFST,
      PMA_OC_OFST, PMA_RXBUF_OFST, PMA_DCD_OFST: is_rmw_offset = 1'b1;
      default: is_rmw_offset = 1'b0;
    endcase
  endfunction

  function automatic mif_ctrl_pkg::ctrl_data_t rmw_mask_of(
    input mif_ctrl_pkg::ctrl_addr_t addr
  );
    case (addr)
      PMA_CGB_OFST:   rmw_mask_of = PMA_CGB_MASK;
      PMA_BBPD_OFST:  rmw_mask_of = PMA_BBPD_MASK;
      PMA_RREF_OFST:  rmw_mask_of = PMA_RREF_MASK;
      PMA_OC_OFST:    rmw_mask_of = PMA_OC_MASK;
      PMA_RXBUF_OFST: rmw_mask_of = PMA_RXBUF_MASK;
      PMA_DCD_OFST:   rmw_mask_of = PMA_DCD_MASK;
      default:        rmw_mask_of = 16'h0000;  // fully writable
    endcase
  endfunction

endpackage

// File: verilog/mif_ctrl_regs.sv
// MIF user register file
`timescale 1ns/100ps

module mif_ctrl_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       uif_go,
  input  mif_ctrl_pkg::uif_mode_e    uif_mode,
  input  mif_ctrl_pkg::mif_mode_e    uif_mif_mode,
  input  mif_ctrl_pkg::ctrl_addr_t   uif_addr,
  input  mif_ctrl_pkg::uif_data_t    uif_wdata,
  input  mif_ctrl_pkg::ctrl_data_t   ctrl_rdata,
  input  logic                       av_opcode_err,
  input  logic                       av_pll_err,
  output mif_ctrl_pkg::uif_data_t    uif_rdata,
  output logic                       uif_addr_err,
  output mif_ctrl_pkg::mif_base_t    mif_base_addr,
  output logic                       mif_addr_mode,
  output logic                       mif_strm_start,
  output logic                       ctrl_op_err
);
  import mif_ctrl_pkg::*;

  logic     strm_wr;
  logic     strm_rd;
  logic     clr_err;        // self-clearing
  logic     addr_err_cond;
  logic     addr_err_dly;
  logic     addr_err_re;
  mif_err_t err_reg;

  assign strm_wr = uif_go && (uif_mode == UIF_MODE_WR) && (uif_mif_mode == MIF_STREAM_MODE);
  assign strm_rd = uif_go && (uif_mode == UIF_MODE_RD) && (uif_mif_mode == MIF_STREAM_MODE);

  ////////////////////
  // register writes
  ////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mif_base_addr  <= '0;
      mif_addr_mode  <= 1'b0;
      mif_strm_start <= 1'b0;
      clr_err        <= 1'b0;
    end else begin
      mif_strm_start <= 1'b0;  // one-cycle strobes
      clr_err        <= 1'b0;
      if (strm_wr) begin
        case (uif_addr)
          MIF_ADDR_OFFSET: mif_base_addr <= uif_wdata;
          MIF_CTRL_OFFSET: begin
            mif_strm_start <= uif_wdata[0];
            mif_addr_mode  <= uif_wdata[1];
            clr_err        <= uif_wdata[2];
          end
          default: ;
        endcase
      end
    end
  end

  // read mux, direct modes track the basic block
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      uif_rdata <= '0;
    end else if (strm_rd) begin
      case (uif_addr)
        MIF_ADDR_OFFSET: uif_rdata <= mif_base_addr;
        MIF_ERR_OFFSET:  uif_rdata <= uif_data_t'(err_reg);
        default:         uif_rdata <= '0;
      endcase
    end else if ((uif_mode == UIF_MODE_RD) && (uif_mif_mode != MIF_STREAM_MODE)) begin
      uif_rdata <= uif_data_t'(ctrl_rdata);
    end
  end

  ////////////////////
  // error status
  ////////////////////
  assign addr_err_cond = (uif_mif_mode == MIF_STREAM_MODE) && (uif_addr > MIF_LAST_OFFSET);
  assign addr_err_re   = uif_addr_err & ~addr_err_dly;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      uif_addr_err <= 1'b0;
      addr_err_dly <= 1'b0;
    end else begin
      uif_addr_err <= addr_err_cond;
      addr_err_dly <= uif_addr_err;
    end
  end

  // sticky bits, lowest bit first on coinciding strobes
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      err_reg <= '0;
    end else if (clr_err) begin
      err_reg <= '0;
    end else if (addr_err_re) begin
      err_reg[0] <= 1'b1;
    end else if (av_opcode_err) begin
      err_reg[1] <= 1'b1;
    end else if (av_pll_err) begin
      err_reg[2] <= 1'b1;
    end
  end

  assign ctrl_op_err = |err_reg;

endmodule

// File: verilog/mif_ctrl_fsm.sv
// MIF control state machine
`timescale 1ns/100ps

module mif_ctrl_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     uif_go,
  input  mif_ctrl_pkg::uif_mode_e  uif_mode,
  input  mif_ctrl_pkg::mif_mode_e  uif_mif_mode,
  input  logic                     mif_strm_start,
  input  logic                     av_ctrl_req,
  input  logic                     av_addr_burst,
  input  logic                     av_done,
  input  logic                     ctrl_wait,
  input  logic                     rmw_needed,
  output logic                     uif_busy,
  output logic                     ctrl_go,
  output mif_ctrl_pkg::ctrl_op_e   ctrl_opcode,
  output logic                     ctrl_lock,
  output logic                     ctrl_av_go,
  output logic                     ctrl_op_done,
  output logic                     uif_accept,
  output logic                     read_done,
  output logic                     rmw_done
);
  import mif_ctrl_pkg::*;

  ctrl_state_e state;
  ctrl_state_e next_state;
  logic        uif_rd;
  logic        uif_wr;
  logic        read_op;      // last issued opcode was a read
  logic        user_pend;    // access belongs to the user port
  logic        phys_req;
  logic        phys_sel;
  logic        rmw_active;   // protected read/write pair in flight
  logic        rmw_active_nxt;
  logic        strm_go;

  assign uif_rd  = uif_go && (uif_mode == UIF_MODE_RD) && (uif_mif_mode != MIF_STREAM_MODE);
  assign uif_wr  = uif_go && (uif_mode == UIF_MODE_WR) && (uif_mif_mode != MIF_STREAM_MODE);
  assign read_op = (ctrl_opcode == CTRL_OP_RD) || (ctrl_opcode == CTRL_OP_PRD);

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    next_state = state;
    case (state)
      CTRL_IDLE: begin
        if (mif_strm_start && (uif_mif_mode == MIF_STREAM_MODE))
          next_state = CTRL_WF_AV;
        else if (uif_rd)
          next_state = CTRL_MIF_RD;
        else if (uif_wr)
          next_state = CTRL_CHK_ADDR;
      end
      CTRL_WF_AV: begin
        if (av_done)
          next_state = CTRL_IDLE;
        else if (av_ctrl_req)
          next_state = CTRL_CHK_ADDR;  // address captured on this edge
      end
      CTRL_CHK_ADDR: next_state = rmw_needed ? CTRL_MIF_RD : CTRL_MIF_WR;
      CTRL_MIF_RD:   next_state = CTRL_WF_B;
      CTRL_MIF_WR:   next_state = CTRL_WF_B;
      CTRL_WF_B: begin
        if (!ctrl_wait) begin
          if (rmw_active && read_op)
            next_state = CTRL_RMW;   // old word is in, merge next
          else if (user_pend)
            next_state = CTRL_IDLE;
          else
            next_state = CTRL_WF_AV;
        end
      end
      CTRL_RMW: next_state = CTRL_MIF_WR;
      default:  next_state = CTRL_IDLE;
    endcase
  end

  // strobes to the datapath and avalon reader
  assign strm_go      = (state == CTRL_IDLE) && (next_state == CTRL_WF_AV);
  assign uif_accept   = (state == CTRL_IDLE) &&
                        ((next_state == CTRL_CHK_ADDR) || (next_state == CTRL_MIF_RD));
  assign ctrl_op_done = (state == CTRL_WF_B) &&
                        ((next_state == CTRL_WF_AV) || (next_state == CTRL_IDLE));
  assign read_done    = (state == CTRL_WF_B) && !ctrl_wait && read_op;
  assign rmw_done     = (state == CTRL_RMW) && (next_state == CTRL_MIF_WR);

  assign rmw_active_nxt = ((state == CTRL_CHK_ADDR) && rmw_needed) ||
                          (rmw_active && !ctrl_op_done);
  assign phys_sel       = (state == CTRL_IDLE) ? (uif_mif_mode == UIF_PDIRECT_MODE) : phys_req;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= CTRL_IDLE;
      user_pend  <= 1'b0;
      phys_req   <= 1'b0;
      rmw_active <= 1'b0;
    end else begin
      state      <= next_state;
      rmw_active <= rmw_active_nxt;
      if (uif_accept)
        user_pend <= 1'b1;
      else if (ctrl_op_done)
        user_pend <= 1'b0;
      if (uif_accept)
        phys_req <= (uif_mif_mode == UIF_PDIRECT_MODE);
      else if (strm_go)
        phys_req <= 1'b0;   // stream uses logical opcodes
    end
  end

  ////////////////////
  // registered outputs
  ////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      uif_busy    <= 1'b0;
      ctrl_go     <= 1'b0;
      ctrl_lock   <= 1'b0;
      ctrl_av_go  <= 1'b0;
      ctrl_opcode <= CTRL_OP_RD;
    end else begin
      uif_busy   <= (state != CTRL_IDLE);  // one cycle behind the state
      ctrl_go    <= (next_state == CTRL_MIF_WR) || (next_state == CTRL_MIF_RD);
      ctrl_lock  <= rmw_active_nxt || av_addr_burst;
      ctrl_av_go <= strm_go;
      if (next_state == CTRL_MIF_WR)
        ctrl_opcode <= phys_sel ? CTRL_OP_PWR : CTRL_OP_WR;
      else if (next_state == CTRL_MIF_RD)
        ctrl_opcode <= phys_sel ? CTRL_OP_PRD : CTRL_OP_RD;
    end
  end

endmodule

// File: verilog/mif_rmw_datapath.sv
// MIF address and RMW datapath
`timescale 1ns/100ps

module mif_rmw_datapath (
  input  logic                      clk,
  input  logic                      reset,
  input  mif_ctrl_pkg::mif_mode_e   uif_mif_mode,
  input  mif_ctrl_pkg::ctrl_addr_t  uif_addr,
  input  mif_ctrl_pkg::uif_data_t   uif_wdata,
  input  mif_ctrl_pkg::av_addr_t    av_mif_addr,
  input  mif_ctrl_pkg::ctrl_data_t  av_mif_data,
  input  logic                      av_ctrl_req,
  input  mif_ctrl_pkg::ctrl_data_t  ctrl_rdata,
  input  logic                      uif_accept,
  input  logic                      read_done,
  input  logic                      rmw_done,
  output logic                      rmw_needed,
  output mif_ctrl_pkg::ctrl_addr_t  ctrl_addr,
  output mif_ctrl_pkg::ctrl_data_t  ctrl_wdata
);
  import mif_ctrl_pkg::*;
  import pma_rmw_pkg::*;

  logic       av_req_dly;
  logic       av_capture;
  logic       uif_capture;
  logic       user_src;     // write data comes from the user port
  logic       rmw_sel;      // merge enabled for the captured address
  ctrl_addr_t av_addr_ext;
  ctrl_data_t user_data;
  ctrl_data_t saved_rdata;
  ctrl_data_t rmw_mask;
  ctrl_data_t new_data;

  assign av_addr_ext = ctrl_addr_t'(av_mif_addr);
  assign av_capture  = av_ctrl_req && !av_req_dly && (uif_mif_mode == MIF_STREAM_MODE);
  assign uif_capture = uif_accept && (uif_mif_mode != MIF_STREAM_MODE);

  ////////////////////
  // address capture
  ////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      av_req_dly <= 1'b0;
      ctrl_addr  <= '0;
      user_data  <= '0;
      user_src   <= 1'b0;
      rmw_sel    <= 1'b0;
      rmw_needed <= 1'b0;
    end else begin
      av_req_dly <= av_ctrl_req;
      if (av_capture) begin
        ctrl_addr  <= av_addr_ext;
        user_src   <= 1'b0;
        rmw_sel    <= is_rmw_offset(av_addr_ext);
        rmw_needed <= is_rmw_offset(av_addr_ext);
      end else if (uif_capture) begin
        ctrl_addr  <= uif_addr;
        user_data  <= uif_wdata[CTRL_DATA_W-1:0];
        user_src   <= 1'b1;
        // only mode 01 is protected, direct reads never check it
        rmw_sel    <= (uif_mif_mode == MIF_DIRECT_MODE) && is_rmw_offset(uif_addr);
        rmw_needed <= (uif_mif_mode == MIF_DIRECT_MODE) && is_rmw_offset(uif_addr);
      end else if (rmw_done) begin
        rmw_needed <= 1'b0;
      end
    end
  end

  // old word for the merge
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      saved_rdata <= '0;
    else if (read_done)
      saved_rdata <= ctrl_rdata;
  end

  ////////////////////
  // write data merge
  ////////////////////
  assign rmw_mask = rmw_sel ? rmw_mask_of(ctrl_addr) : '0;
  assign new_data = user_src ? user_data : av_mif_data;

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ctrl_wdata <= '0;
    else
      ctrl_wdata <= (new_data & ~rmw_mask) | (saved_rdata & rmw_mask);
  end

endmodule

// File: verilog/mif_ctrl_top.sv
// MIF reconfiguration controller
`timescale 1ns/100ps

module mif_ctrl_top (
  input  logic                      clk,
  input  logic                      reset,
  // user register port
  input  logic                      uif_go,
  input  mif_ctrl_pkg::uif_mode_e   uif_mode,
  input  mif_ctrl_pkg::mif_mode_e   uif_mif_mode,
  input  mif_ctrl_pkg::ctrl_addr_t  uif_addr,
  input  mif_ctrl_pkg::uif_data_t   uif_wdata,
  output logic                      uif_busy,
  output mif_ctrl_pkg::uif_data_t   uif_rdata,
  output logic                      uif_addr_err,
  // avalon reader
  output mif_ctrl_pkg::mif_base_t   mif_base_addr,
  output logic                      mif_addr_mode,
  output logic                      ctrl_av_go,
  output logic                      ctrl_op_done,
  output logic                      ctrl_op_err,
  input  mif_ctrl_pkg::av_addr_t    av_mif_addr,
  input  mif_ctrl_pkg::ctrl_data_t  av_mif_data,
  input  logic                      av_ctrl_req,
  input  logic                      av_addr_burst,
  input  logic                      av_opcode_err,
  input  logic                      av_pll_err,
  input  logic                      av_done,
  // basic block
  output logic                      ctrl_go,
  output mif_ctrl_pkg::ctrl_op_e    ctrl_opcode,
  output logic                      ctrl_lock,
  input  logic                      ctrl_wait,
  output mif_ctrl_pkg::ctrl_addr_t  ctrl_addr,
  input  mif_ctrl_pkg::ctrl_data_t  ctrl_rdata,
  output mif_ctrl_pkg::ctrl_data_t  ctrl_wdata
);

  logic mif_strm_start;
  logic uif_accept;
  logic read_done;
  logic rmw_done;
  logic rmw_needed;

  mif_ctrl_regs mif_ctrl_regs_inst (
    .clk            (clk),
    .reset          (reset),
    .uif_go         (uif_go),
    .uif_mode       (uif_mode),
    .uif_mif_mode   (uif_mif_mode),
    .uif_addr       (uif_addr),
    .uif_wdata      (uif_wdata),
    .ctrl_rdata     (ctrl_rdata),
    .av_opcode_err  (av_opcode_err),
    .av_pll_err     (av_pll_err),
    .uif_rdata      (uif_rdata),
    .uif_addr_err   (uif_addr_err),
    .mif_base_addr  (mif_base_addr),
    .mif_addr_mode  (mif_addr_mode),
    .mif_strm_start (mif_strm_start),
    .ctrl_op_err    (ctrl_op_err)
  );

  mif_ctrl_fsm mif_ctrl_fsm_inst (
    .clk            (clk),
    .reset          (reset),
    .uif_go         (uif_go),
    .uif_mode       (uif_mode),
    .uif_mif_mode   (uif_mif_mode),
    .mif_strm_start (mif_strm_start),
    .av_ctrl_req    (av_ctrl_req),
    .av_addr_burst  (av_addr_burst),
    .av_done        (av_done),
    .ctrl_wait      (ctrl_wait),
    .rmw_needed     (rmw_needed),
    .uif_busy       (uif_busy),
    .ctrl_go        (ctrl_go),
    .ctrl_opcode    (ctrl_opcode),
    .ctrl_lock      (ctrl_lock),
    .ctrl_av_go     (ctrl_av_go),
    .ctrl_op_done   (ctrl_op_done),
    .uif_accept     (uif_accept),
    .read_done      (read_done),
    .rmw_done       (rmw_done)
  );

  mif_rmw_datapath mif_rmw_datapath_inst (
    .clk            (clk),
    .reset          (reset),
    .uif_mif_mode   (uif_mif_mode),
    .uif_addr       (uif_addr),
    .uif_wdata      (uif_wdata),
    .av_mif_addr    (av_mif_addr),
    .av_mif_data    (av_mif_data),
    .av_ctrl_req    (av_ctrl_req),
    .ctrl_rdata     (ctrl_rdata),
    .uif_accept     (uif_accept),
    .read_done      (read_done),
    .rmw_done       (rmw_done),
    .rmw_needed     (rmw_needed),
    .ctrl_addr      (ctrl_addr),
    .ctrl_wdata     (ctrl_wdata)
  );

endmodule

// File: tests/basic_block_model.sv
// Basic block memory model
`timescale 1ns/100ps

module basic_block_model (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ctrl_go,
  input  mif_ctrl_pkg::ctrl_op_e    ctrl_opcode,
  input  mif_ctrl_pkg::ctrl_addr_t  ctrl_addr,
  input  mif_ctrl_pkg::ctrl_data_t  ctrl_wdata,
  output logic                      ctrl_wait,
  output mif_ctrl_pkg::ctrl_data_t  ctrl_rdata,
  output mif_ctrl_pkg::ctrl_op_e    last_op
);
  import mif_ctrl_pkg::*;

  ctrl_data_t mem [0:4095];
  ctrl_addr_t acc_addr;
  ctrl_data_t acc_data;
  logic [2:0] wait_cnt;

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_wait  <= 1'b0;
      ctrl_rdata <= '0;
      acc_addr   <= '0;
      acc_data   <= '0;
      wait_cnt   <= '0;
      last_op    <= CTRL_OP_RD;
      for (int i = 0; i < 4096; i++)
        mem[i] <= ctrl_data_t'($urandom);  // random preload
    end else if (ctrl_go && !ctrl_wait) begin
      last_op   <= ctrl_opcode;
      acc_addr  <= ctrl_addr;
      acc_data  <= ctrl_wdata;
      ctrl_wait <= 1'b1;
      wait_cnt  <= 3'($urandom_range(4, 1));
    end else if (ctrl_wait) begin
      if (wait_cnt == 3'd1) begin
        ctrl_wait <= 1'b0;
        if ((last_op == CTRL_OP_WR) || (last_op == CTRL_OP_PWR))
          mem[acc_addr] <= acc_data;
        else
          ctrl_rdata <= mem[acc_addr];  // valid while wait is low
      end else begin
        wait_cnt <= wait_cnt - 3'd1;
      end
    end
  end

endmodule

// File: tests/tb_mif_ctrl.sv
// MIF controller testbench
`timescale 1ns/100ps

module tb_mif_ctrl;
  import mif_ctrl_pkg::*;
  import pma_rmw_pkg::*;

  logic       clk;
  logic       reset;
  logic       uif_go;
  uif_mode_e  uif_mode;
  mif_mode_e  uif_mif_mode;
  ctrl_addr_t uif_addr;
  uif_data_t  uif_wdata;
  logic       uif_busy;
  uif_data_t  uif_rdata;
  logic       uif_addr_err;
  mif_base_t  mif_base_addr;
  logic       mif_addr_mode;
  logic       ctrl_av_go;
  logic       ctrl_op_done;
  logic       ctrl_op_err;
  av_addr_t   av_mif_addr;
  ctrl_data_t av_mif_data;
  logic       av_ctrl_req;
  logic       av_addr_burst;
  logic       av_opcode_err;
  logic       av_pll_err;
  logic       av_done;
  logic       ctrl_go;
  ctrl_op_e   ctrl_opcode;
  logic       ctrl_lock;
  logic       ctrl_wait;
  ctrl_addr_t ctrl_addr;
  ctrl_data_t ctrl_rdata;
  ctrl_data_t ctrl_wdata;
  ctrl_op_e   last_op;

  int errors;
  int checks;
  int op_done_total;
  int lock_total;
  logic busy_at_done;
  av_addr_t   strm_addr [6];
  ctrl_data_t strm_data [6];

  mif_ctrl_top mif_ctrl_top_inst (.*);

  basic_block_model bb_model_inst (
    .clk         (clk),
    .reset       (reset),
    .ctrl_go     (ctrl_go),
    .ctrl_opcode (ctrl_opcode),
    .ctrl_addr   (ctrl_addr),
    .ctrl_wdata  (ctrl_wdata),
    .ctrl_wait   (ctrl_wait),
    .ctrl_rdata  (ctrl_rdata),
    .last_op     (last_op)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // monitors sample mid-cycle
  always @(negedge clk) begin
    if (ctrl_op_done)
      op_done_total <= op_done_total + 1;
    if (ctrl_lock)
      lock_total <= lock_total + 1;
  end

  ////////////////////
  // reference and checks
  ////////////////////
  function automatic ctrl_data_t expected_word(ctrl_data_t new_data, ctrl_data_t old_word,
                                               ctrl_data_t mask);
    ctrl_data_t word;
    for (int b = 0; b < CTRL_DATA_W; b++)
      word[b] = mask[b] ? old_word[b] : new_data[b];  // set mask bit keeps old bit
    return word;
  endfunction

  task automatic check_data(input string name, input ctrl_data_t exp, input ctrl_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input uif_data_t exp, input uif_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input mif_err_t exp, input mif_err_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_op(input string name, input ctrl_op_e exp, input ctrl_op_e act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic abort_run();
    $display("Regression failed");
    $finish;
  endtask

  task automatic report_test(input int num, input string name, input int err_start);
    if (errors == err_start)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: %0d mismatches", num, name, errors - err_start);
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////
  task automatic user_op(input uif_mode_e op, input mif_mode_e mode, input ctrl_addr_t addr,
                         input uif_data_t data);
    @(posedge clk);
    uif_go       <= 1'b1;
    uif_mode     <= op;
    uif_mif_mode <= mode;
    uif_addr     <= addr;
    uif_wdata    <= data;
    @(posedge clk);
    uif_go <= 1'b0;
  endtask

  task automatic wait_busy(input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while ((uif_busy !== level) && (cycles < 200)) begin
      @(negedge clk);
      cycles++;
    end
    if (uif_busy !== level) begin
      $display("timeout: uif_busy never went to %0b during %s", level, what);
      abort_run();
    end
  endtask

  // full direct access, ends when busy falls
  task automatic direct_op(input uif_mode_e op, input mif_mode_e mode, input ctrl_addr_t addr,
                           input uif_data_t data);
    user_op(op, mode, addr, data);
    wait_busy(1'b1, "direct access start");
    wait_busy(1'b0, "direct access end");
  endtask

  task automatic reg_read(input ctrl_addr_t offset, output uif_data_t value);
    user_op(UIF_MODE_RD, MIF_STREAM_MODE, offset, '0);
    @(negedge clk);
    value = uif_rdata;
  endtask

  // avalon reader stub
  task automatic run_stream(input int n);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ctrl_av_go && (cycles < 200)) begin
      @(negedge clk);
      cycles++;
    end
    if (!ctrl_av_go) begin
      $display("timeout: ctrl_av_go never pulsed after stream start");
      abort_run();
    end
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      av_mif_addr <= strm_addr[i];
      av_mif_data <= strm_data[i];
      av_ctrl_req <= 1'b1;
      cycles = 0;
      @(negedge clk);
      while (!ctrl_op_done && (cycles < 200)) begin
        @(negedge clk);
        cycles++;
      end
      if (!ctrl_op_done) begin
        $display("timeout: no ctrl_op_done for stream word %0d", i);
        abort_run();
      end
      @(posedge clk);
      av_ctrl_req <= 1'b0;
      @(posedge clk);
    end
    @(posedge clk);
    av_done <= 1'b1;
    @(negedge clk);
    busy_at_done = uif_busy;  // still busy while av_done is seen
    @(posedge clk);
    av_done <= 1'b0;
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin
    uif_data_t  rd;
    ctrl_data_t old_word [6];
    ctrl_data_t wdata;
    ctrl_addr_t addr;
    int err_start;
    int count_start;

    void'($urandom(32'h4e77d13d));
    errors        = 0;
    checks        = 0;
    op_done_total = 0;
    lock_total    = 0;
    busy_at_done  = 1'b0;
    reset         = 1'b1;
    uif_go        = 1'b0;
    uif_mode      = UIF_MODE_RD;
    uif_mif_mode  = MIF_STREAM_MODE;
    uif_addr      = '0;
    uif_wdata     = '0;
    av_mif_addr   = '0;
    av_mif_data   = '0;
    av_ctrl_req   = 1'b0;
    av_addr_burst = 1'b0;
    av_opcode_err = 1'b0;
    av_pll_err    = 1'b0;
    av_done       = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    // 1: reset values and stream registers
    err_start = errors;
    @(negedge clk);
    check_flag("uif_busy", 1'b0, uif_busy);
    check_flag("ctrl_go", 1'b0, ctrl_go);
    check_flag("ctrl_av_go", 1'b0, ctrl_av_go);
    check_flag("ctrl_op_err", 1'b0, ctrl_op_err);
    user_op(UIF_MODE_WR, MIF_STREAM_MODE, MIF_ADDR_OFFSET, 32'h1234_abcd);
    reg_read(MIF_ADDR_OFFSET, rd);
    check_word("uif_rdata base", 32'h1234_abcd, rd);
    check_word("mif_base_addr", 32'h1234_abcd, mif_base_addr);
    reg_read(MIF_ERR_OFFSET, rd);
    check_word("uif_rdata err", '0, rd);
    report_test(1, "reset and registers", err_start);

    // 2: logical and physical direct access
    err_start = errors;
    addr  = 12'h345;
    wdata = ctrl_data_t'($urandom);
    direct_op(UIF_MODE_WR, UIF_LDIRECT_MODE, addr, {16'(($urandom)), wdata});
    check_op("ctrl_opcode", CTRL_OP_WR, last_op);
    check_data("mem", expected_word(wdata, '0, '0), bb_model_inst.mem[addr]);
    direct_op(UIF_MODE_RD, UIF_LDIRECT_MODE, addr, '0);
    check_op("ctrl_opcode", CTRL_OP_RD, last_op);
    check_data("uif_rdata", wdata, uif_rdata[15:0]);
    addr  = 12'h7a2;
    wdata = ctrl_data_t'($urandom);
    direct_op(UIF_MODE_WR, UIF_PDIRECT_MODE, addr, uif_data_t'(wdata));
    check_op("ctrl_opcode", CTRL_OP_PWR, last_op);
    direct_op(UIF_MODE_RD, UIF_PDIRECT_MODE, addr, '0);
    check_op("ctrl_opcode", CTRL_OP_PRD, last_op);
    check_data("uif_rdata", wdata, uif_rdata[15:0]);
    report_test(2, "direct access", err_start);

    // 3: protected write in mode 01
    err_start   = errors;
    addr        = PMA_OC_OFST;
    wdata       = ctrl_data_t'($urandom);
    old_word[0] = bb_model_inst.mem[addr];
    count_start = lock_total;
    direct_op(UIF_MODE_WR, MIF_DIRECT_MODE, addr, uif_data_t'(wdata));
    check_data("mem", expected_word(wdata, old_word[0], rmw_mask_of(addr)),
               bb_model_inst.mem[addr]);
    check_flag("ctrl_lock seen", 1'b1, lock_total > count_start);
    report_test(3, "protected direct write", err_start);

    // 4: six word stream, three protected
    err_start = errors;
    strm_addr[0] = 11'h011;
    strm_addr[1] = 11'h100;
    strm_addr[2] = 11'h01c;
    strm_addr[3] = 11'h101;
    strm_addr[4] = 11'h02e;
    strm_addr[5] = 11'h200;
    for (int i = 0; i < 6; i++) begin
      strm_data[i] = ctrl_data_t'($urandom);
      old_word[i]  = bb_model_inst.mem[ctrl_addr_t'(strm_addr[i])];
    end
    count_start  = op_done_total;
    busy_at_done = 1'b0;
    user_op(UIF_MODE_WR, MIF_STREAM_MODE, MIF_CTRL_OFFSET, 32'h3);  // start, address mode
    run_stream(6);
    wait_busy(1'b0, "stream end");
    check_flag("uif_busy during av_done", 1'b1, busy_at_done);
    check_flag("mif_addr_mode", 1'b1, mif_addr_mode);
    check_word("ctrl_op_done count", 32'd6, uif_data_t'(op_done_total - count_start));
    for (int i = 0; i < 6; i++) begin
      addr = ctrl_addr_t'(strm_addr[i]);
      check_data("mem", expected_word(strm_data[i], old_word[i], rmw_mask_of(addr)),
                 bb_model_inst.mem[addr]);
    end
    report_test(4, "stream", err_start);

    // 5: sticky error bits and clear
    err_start = errors;
    user_op(UIF_MODE_RD, MIF_STREAM_MODE, 12'd5, '0);
    @(negedge clk);
    check_flag("uif_addr_err", 1'b1, uif_addr_err);
    repeat (3) @(posedge clk);
    av_opcode_err <= 1'b1;
    @(posedge clk);
    av_opcode_err <= 1'b0;
    repeat (2) @(posedge clk);
    av_pll_err <= 1'b1;
    @(posedge clk);
    av_pll_err <= 1'b0;
    reg_read(MIF_ERR_OFFSET, rd);
    check_err("err status", 3'b111, mif_err_t'(rd));
    check_flag("ctrl_op_err", 1'b1, ctrl_op_err);
    check_flag("uif_addr_err", 1'b0, uif_addr_err);
    user_op(UIF_MODE_WR, MIF_STREAM_MODE, MIF_CTRL_OFFSET, 32'h4);
    repeat (2) @(posedge clk);
    reg_read(MIF_ERR_OFFSET, rd);
    check_err("err status", 3'b000, mif_err_t'(rd));
    check_flag("ctrl_op_err", 1'b0, ctrl_op_err);
    check_flag("mif_addr_mode", 1'b0, mif_addr_mode);
    report_test(5, "error status", err_start);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// File: filelist.f
verilog/mif_ctrl_pkg.sv
verilog/pma_rmw_pkg.sv
verilog/mif_ctrl_regs.sv
verilog/mif_ctrl_fsm.sv
verilog/mif_rmw_datapath.sv
verilog/mif_ctrl_top.sv
tests/basic_block_model.sv
tests/tb_mif_ctrl.sv

// File: Makefile
# Verilator build for the MIF controller testbench

TOP := tb_mif_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f verilog/*.sv tests/*.sv
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
